// File: common/p4_proc_pkg.sv
package p4_proc_pkg;

    // ==============================
    // Packet path widths
    // ==============================

    // Ingress or egress port number, two ports
    typedef logic [0:0] port_t;

    // Flow key carried by each descriptor
    typedef logic [7:0] flow_key_t;

    // Packet length in bytes
    typedef logic [15:0] pkt_len_t;

    // VLAN id attached on the way out
    typedef logic [11:0] vlan_t;

    // Per-port drop counter, saturates at all ones
    typedef logic [15:0] cnt_t;

endpackage

// File: common/tbl_pkg.sv
package tbl_pkg;

    // ==============================
    // Table storage
    // ==============================

    // Table index, same width as the flow key
    typedef logic [7:0] tbl_addr_t;

    // Match-action entry
    typedef logic [15:0] tbl_entry_t;

    // Entry field positions (bit 12 is spare)
    localparam int ENT_VALID_BIT  = 15;
    localparam int ENT_DROP_BIT   = 14;
    localparam int ENT_EGRESS_BIT = 13;
    localparam int ENT_VLAN_MSB   = 11;
    localparam int ENT_VLAN_LSB   = 0;

    // ==============================
    // Requester side of a table access
    // ==============================

    typedef enum logic [1:0] {
        req_idle,
        req_wait_ack,
        req_release
    } tbl_req_state_t;

endpackage

// File: common/tbl_bus_if.sv
interface tbl_bus_if;

    // Requester side
    logic                req;
    logic                we;
    tbl_pkg::tbl_addr_t  addr;
    tbl_pkg::tbl_entry_t wdata;

    // Arbiter side, rdata valid while ack is high
    logic                ack;
    tbl_pkg::tbl_entry_t rdata;

    modport requester (
        output req, we, addr, wdata,
        input  ack, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output ack, rdata
    );

endinterface

// File: table/tbl_mem.sv
module tbl_mem #(
    parameter int KEY_WID = 8
) (
    input  logic                axil_if,
    input  logic                en,
    input  logic                we,
    input  tbl_pkg::tbl_addr_t  addr,
    input  tbl_pkg::tbl_entry_t wdata,
    output tbl_pkg::tbl_entry_t rdata
);

    localparam int DEPTH = 2 ** KEY_WID;

    tbl_pkg::tbl_entry_t mem_q [DEPTH];

    // Single port, write wins, read data one cycle after en
    always_ff @(posedge axil_if) begin
        if (en) begin
            if (we) begin
                mem_q[addr[KEY_WID-1:0]] <= wdata;
            end else begin
                rdata <= mem_q[addr[KEY_WID-1:0]];
            end
        end
    end

endmodule

// File: table/tbl_arbiter.sv
module tbl_arbiter (
    input  logic                axil_if,
    input  logic                rst_n,

    // Requesters, lookup 0, lookup 1 and management
    tbl_bus_if.arbiter          lk0,
    tbl_bus_if.arbiter          lk1,
    tbl_bus_if.arbiter          mgmt,

    // Table memory
    output logic                mem_en,
    output logic                mem_we,
    output tbl_pkg::tbl_addr_t  mem_addr,
    output tbl_pkg::tbl_entry_t mem_wdata,
    input  tbl_pkg::tbl_entry_t mem_rdata
);

    localparam int NUM_REQ = 3;

    typedef enum logic [1:0] {
        arb_idle,
        arb_access,
        arb_capture,
        arb_ack
    } arb_state_t;

    arb_state_t          state_q;
    logic [1:0]          last_q;
    logic [1:0]          grant_q;
    logic [1:0]          next_grant;
    logic                found;
    logic [NUM_REQ-1:0]  ack_q;
    tbl_pkg::tbl_entry_t rdata_q;

    logic [NUM_REQ-1:0]  req_v;
    logic [NUM_REQ-1:0]  we_v;
    tbl_pkg::tbl_addr_t  addr_v [NUM_REQ];
    tbl_pkg::tbl_entry_t wdata_v [NUM_REQ];

    // Gather the requesters into arrays
    assign req_v      = {mgmt.req, lk1.req, lk0.req};
    assign we_v       = {mgmt.we, lk1.we, lk0.we};
    assign addr_v[0]  = lk0.addr;
    assign addr_v[1]  = lk1.addr;
    assign addr_v[2]  = mgmt.addr;
    assign wdata_v[0] = lk0.wdata;
    assign wdata_v[1] = lk1.wdata;
    assign wdata_v[2] = mgmt.wdata;

    assign lk0.ack    = ack_q[0];
    assign lk1.ack    = ack_q[1];
    assign mgmt.ack   = ack_q[2];
    assign lk0.rdata  = rdata_q;
    assign lk1.rdata  = rdata_q;
    assign mgmt.rdata = rdata_q;

    // ==============================
    // Round-robin pick
    // ==============================

    // Search starts just after the last grant
    always_comb begin
        int idx;
        next_grant = last_q;
        found      = 1'b0;
        for (int i = 1; i <= NUM_REQ; i++) begin
            idx = (int'(last_q) + i) % NUM_REQ;
            if (!found && req_v[idx]) begin
                next_grant = 2'(idx);
                found      = 1'b1;
            end
        end
    end

    // Memory sees the granted access for one cycle
    assign mem_en    = (state_q == arb_access);
    assign mem_we    = mem_en && we_v[grant_q];
    assign mem_addr  = addr_v[grant_q];
    assign mem_wdata = wdata_v[grant_q];

    // ==============================
    // Grant sequence
    // ==============================

    always_ff @(posedge axil_if or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= arb_idle;
            last_q  <= 2'd2;
            grant_q <= 2'd0;
            ack_q   <= '0;
        end else begin
            case (state_q)
                arb_idle: begin
                    if (found) begin
                        grant_q <= next_grant;
                        last_q  <= next_grant;
                        state_q <= arb_access;
                    end
                end
                arb_access:  state_q <= arb_capture;
                arb_capture: begin
                    ack_q[grant_q] <= 1'b1;
                    state_q        <= arb_ack;
                end
                arb_ack: begin
                    // Grant held until the requester lets go
                    if (!req_v[grant_q]) begin
                        ack_q[grant_q] <= 1'b0;
                        state_q        <= arb_idle;
                    end
                end
                default: state_q <= arb_idle;
            endcase
        end
    end

    always_ff @(posedge axil_if) begin
        if (state_q == arb_capture) begin
            rdata_q <= mem_rdata;
        end
    end

endmodule

// File: match_action/flow_lookup.sv
module flow_lookup #(
    parameter int                 KEY_WID = 8,
    parameter p4_proc_pkg::port_t PORT_ID = 1'b0
) (
    input  logic                   axil_if,
    input  logic                   rst_n,

    // Descriptor in
    input  logic                   in_valid,
    output logic                   in_ready,
    input  p4_proc_pkg::flow_key_t in_key,
    input  p4_proc_pkg::pkt_len_t  in_len,

    // Descriptor out
    output logic                   out_valid,
    input  logic                   out_ready,
    output p4_proc_pkg::flow_key_t out_key,
    output p4_proc_pkg::pkt_len_t  out_len,
    output p4_proc_pkg::port_t     out_egress,
    output p4_proc_pkg::vlan_t     out_vlan,

    // One-hot drop pulse, bit PORT_ID
    output logic [1:0]             drop,

    tbl_bus_if.requester           tbl
);

    tbl_pkg::tbl_req_state_t state_q;
    tbl_pkg::tbl_entry_t     entry_q;
    logic                    hit;

    // Only accept out of reset, while idle with nothing waiting on the output
    assign in_ready = rst_n && (state_q == tbl_pkg::req_idle) && !out_valid;

    // Lookups only ever read
    assign tbl.we    = 1'b0;
    assign tbl.wdata = '0;
    assign tbl.addr  = tbl_pkg::tbl_addr_t'(out_key[KEY_WID-1:0]);

    // ==============================
    // Entry decode
    // ==============================

    assign hit = entry_q[tbl_pkg::ENT_VALID_BIT] && !entry_q[tbl_pkg::ENT_DROP_BIT];

    // Entry is held until the next descriptor is taken
    assign out_egress = p4_proc_pkg::port_t'(entry_q[tbl_pkg::ENT_EGRESS_BIT]);
    assign out_vlan   = p4_proc_pkg::vlan_t'(
        entry_q[tbl_pkg::ENT_VLAN_MSB:tbl_pkg::ENT_VLAN_LSB]);

    // ==============================
    // Control
    // ==============================

    always_ff @(posedge axil_if or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= tbl_pkg::req_idle;
            tbl.req   <= 1'b0;
            out_valid <= 1'b0;
            drop      <= '0;
        end else begin
            drop <= '0;
            case (state_q)
                tbl_pkg::req_idle: begin
                    if (out_valid && out_ready) begin
                        out_valid <= 1'b0;
                    end
                    if (in_valid && in_ready) begin
                        tbl.req <= 1'b1;
                        state_q <= tbl_pkg::req_wait_ack;
                    end
                end
                tbl_pkg::req_wait_ack: begin
                    if (tbl.ack) begin
                        tbl.req <= 1'b0;
                        state_q <= tbl_pkg::req_release;
                    end
                end
                tbl_pkg::req_release: begin
                    // Access closed once ack falls
                    if (!tbl.ack) begin
                        state_q <= tbl_pkg::req_idle;
                        if (hit) begin
                            out_valid <= 1'b1;
                        end else begin
                            drop[PORT_ID] <= 1'b1;
                        end
                    end
                end
                default: state_q <= tbl_pkg::req_idle;
            endcase
        end
    end

    // Descriptor and entry capture
    always_ff @(posedge axil_if) begin
        if (in_valid && in_ready) begin
            out_key <= in_key;
            out_len <= in_len;
        end
        if (state_q == tbl_pkg::req_wait_ack && tbl.ack) begin
            entry_q <= tbl.rdata;
        end
    end

endmodule

// File: hw/tbl_mgmt.sv
module tbl_mgmt #(
    parameter int KEY_WID = 8
) (
    input  logic                axil_if,
    input  logic                rst_n,

    // Management port
    input  logic                mgmt_req,
    input  logic                mgmt_we,
    input  logic [8:0]          mgmt_addr,
    input  tbl_pkg::tbl_entry_t mgmt_wdata,
    output logic                mgmt_ack,
    output tbl_pkg::tbl_entry_t mgmt_rdata,

    // Drop pulses from the lookups
    input  logic                drop0,
    input  logic                drop1,

    tbl_bus_if.requester        tbl
);

    // Set selects the counter space
    localparam int CNT_SPACE_BIT = 8;

    tbl_pkg::tbl_req_state_t state_q;
    p4_proc_pkg::cnt_t       cnt_q [2];
    logic [1:0]              drops;
    logic                    start;

    assign drops = {drop1, drop0};
    assign start = (state_q == tbl_pkg::req_idle) && mgmt_req && !mgmt_ack;

    // ==============================
    // Drop counters
    // ==============================

    always_ff @(posedge axil_if or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q[0] <= '0;
            cnt_q[1] <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (drops[i] && cnt_q[i] != '1) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    // ==============================
    // Access sequence
    // ==============================

    always_ff @(posedge axil_if or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= tbl_pkg::req_idle;
            tbl.req  <= 1'b0;
            mgmt_ack <= 1'b0;
        end else begin
            case (state_q)
                tbl_pkg::req_idle: begin
                    if (mgmt_ack) begin
                        if (!mgmt_req) begin
                            mgmt_ack <= 1'b0;
                        end
                    end else if (mgmt_req) begin
                        // Counter space answered here, writes dropped
                        if (mgmt_addr[CNT_SPACE_BIT]) begin
                            mgmt_ack <= 1'b1;
                        end else begin
                            tbl.req <= 1'b1;
                            state_q <= tbl_pkg::req_wait_ack;
                        end
                    end
                end
                tbl_pkg::req_wait_ack: begin
                    if (tbl.ack) begin
                        tbl.req  <= 1'b0;
                        mgmt_ack <= 1'b1;
                        state_q  <= tbl_pkg::req_release;
                    end
                end
                tbl_pkg::req_release: begin
                    if (!tbl.ack) begin
                        state_q <= tbl_pkg::req_idle;
                    end
                end
                default: state_q <= tbl_pkg::req_idle;
            endcase
        end
    end

    // Request fields and read data
    always_ff @(posedge axil_if) begin
        if (start) begin
            tbl.we     <= mgmt_we;
            tbl.addr   <= tbl_pkg::tbl_addr_t'(mgmt_addr[KEY_WID-1:0]);
            tbl.wdata  <= mgmt_wdata;
            mgmt_rdata <= tbl_pkg::tbl_entry_t'(cnt_q[mgmt_addr[0]]);
        end
        if (state_q == tbl_pkg::req_wait_ack && tbl.ack) begin
            mgmt_rdata <= tbl.rdata;
        end
    end

endmodule

// File: hw/p4_proc_top.sv
module p4_proc_top #(
    parameter int KEY_WID = 8
) (
    input  logic                   axil_if,
    input  logic                   rst_n,

    // Ingress port 0
    input  logic                   in_valid_0,
    output logic                   in_ready_0,
    input  p4_proc_pkg::flow_key_t in_key_0,
    input  p4_proc_pkg::pkt_len_t  in_len_0,

    // Ingress port 1
    input  logic                   in_valid_1,
    output logic                   in_ready_1,
    input  p4_proc_pkg::flow_key_t in_key_1,
    input  p4_proc_pkg::pkt_len_t  in_len_1,

    // Egress port 0
    output logic                   out_valid_0,
    input  logic                   out_ready_0,
    output p4_proc_pkg::flow_key_t out_key_0,
    output p4_proc_pkg::pkt_len_t  out_len_0,
    output p4_proc_pkg::port_t     out_egress_0,
    output p4_proc_pkg::vlan_t     out_vlan_0,

    // Egress port 1
    output logic                   out_valid_1,
    input  logic                   out_ready_1,
    output p4_proc_pkg::flow_key_t out_key_1,
    output p4_proc_pkg::pkt_len_t  out_len_1,
    output p4_proc_pkg::port_t     out_egress_1,
    output p4_proc_pkg::vlan_t     out_vlan_1,

    // Management port
    input  logic                   mgmt_req,
    input  logic                   mgmt_we,
    input  logic [8:0]             mgmt_addr,
    input  tbl_pkg::tbl_entry_t    mgmt_wdata,
    output logic                   mgmt_ack,
    output tbl_pkg::tbl_entry_t    mgmt_rdata
);

    // ==============================
    // Internal wiring
    // ==============================

    tbl_bus_if lk0_bus ();
    tbl_bus_if lk1_bus ();
    tbl_bus_if mgmt_bus ();

    // Each lookup pulses only its own bit
    logic [1:0] drop_lk0;
    logic [1:0] drop_lk1;
    logic [1:0] drop_vec;

    logic                mem_en;
    logic                mem_we;
    tbl_pkg::tbl_addr_t  mem_addr;
    tbl_pkg::tbl_entry_t mem_wdata;
    tbl_pkg::tbl_entry_t mem_rdata;

    assign drop_vec = drop_lk0 | drop_lk1;

    // ==============================
    // Lookup engines
    // ==============================

    flow_lookup #(.KEY_WID(KEY_WID), .PORT_ID(1'b0)) i_lookup_0 (
        .axil_if    (axil_if),
        .rst_n      (rst_n),
        .in_valid   (in_valid_0),
        .in_ready   (in_ready_0),
        .in_key     (in_key_0),
        .in_len     (in_len_0),
        .out_valid  (out_valid_0),
        .out_ready  (out_ready_0),
        .out_key    (out_key_0),
        .out_len    (out_len_0),
        .out_egress (out_egress_0),
        .out_vlan   (out_vlan_0),
        .drop       (drop_lk0),
        .tbl        (lk0_bus.requester)
    );

    flow_lookup #(.KEY_WID(KEY_WID), .PORT_ID(1'b1)) i_lookup_1 (
        .axil_if    (axil_if),
        .rst_n      (rst_n),
        .in_valid   (in_valid_1),
        .in_ready   (in_ready_1),
        .in_key     (in_key_1),
        .in_len     (in_len_1),
        .out_valid  (out_valid_1),
        .out_ready  (out_ready_1),
        .out_key    (out_key_1),
        .out_len    (out_len_1),
        .out_egress (out_egress_1),
        .out_vlan   (out_vlan_1),
        .drop       (drop_lk1),
        .tbl        (lk1_bus.requester)
    );

    // ==============================
    // Management and table
    // ==============================

    tbl_mgmt #(.KEY_WID(KEY_WID)) i_mgmt (
        .axil_if    (axil_if),
        .rst_n      (rst_n),
        .mgmt_req   (mgmt_req),
        .mgmt_we    (mgmt_we),
        .mgmt_addr  (mgmt_addr),
        .mgmt_wdata (mgmt_wdata),
        .mgmt_ack   (mgmt_ack),
        .mgmt_rdata (mgmt_rdata),
        .drop0      (drop_vec[0]),
        .drop1      (drop_vec[1]),
        .tbl        (mgmt_bus.requester)
    );

    tbl_arbiter i_arbiter (
        .axil_if   (axil_if),
        .rst_n     (rst_n),
        .lk0       (lk0_bus.arbiter),
        .lk1       (lk1_bus.arbiter),
        .mgmt      (mgmt_bus.arbiter),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    tbl_mem #(.KEY_WID(KEY_WID)) i_mem (
        .axil_if (axil_if),
        .en      (mem_en),
        .we      (mem_we),
        .addr    (mem_addr),
        .wdata   (mem_wdata),
        .rdata   (mem_rdata)
    );

endmodule

// File: verif/tb_clk_gen.sv
module tb_clk_gen #(
    parameter int CLK_PERIOD_NS  = 100,
    parameter int RESET_CYCLES   = 16,
    parameter int DRIVE_DELAY_NS = 10
) (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    // Reset released just after an edge, like any other input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY_NS);
        rst_n = 1'b1;
    end

endmodule

// File: verif/tb_p4_proc.sv
module tb_p4_proc;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD_NS   = 100;
    localparam int          DRIVE_DELAY_NS  = 10;
    // Longest run is well under half of this
    localparam int          WATCHDOG_CYCLES = 4000;
    localparam int          NUM_ENTRIES     = 32;
    localparam int          STREAM_LEN      = 24;
    localparam int          ACCEPT_TIMEOUT  = 200;
    localparam int          MGMT_TIMEOUT    = 50;
    localparam int          DRAIN_TIMEOUT   = 600;
    localparam logic [31:0] SEED            = 32'h2fd2;

    typedef struct packed {
        logic                   drop;
        p4_proc_pkg::flow_key_t key;
        p4_proc_pkg::pkt_len_t  len;
        p4_proc_pkg::port_t     egress;
        p4_proc_pkg::vlan_t     vlan;
    } expect_t;

    logic axil_if;
    logic rst_n;
    logic in_valid_0, in_ready_0, in_valid_1, in_ready_1;
    p4_proc_pkg::flow_key_t in_key_0, in_key_1, out_key_0, out_key_1;
    p4_proc_pkg::pkt_len_t  in_len_0, in_len_1, out_len_0, out_len_1;
    logic out_valid_0, out_ready_0, out_valid_1, out_ready_1;
    p4_proc_pkg::port_t out_egress_0, out_egress_1;
    p4_proc_pkg::vlan_t out_vlan_0, out_vlan_1;
    logic mgmt_req, mgmt_we, mgmt_ack;
    logic [8:0] mgmt_addr;
    tbl_pkg::tbl_entry_t mgmt_wdata, mgmt_rdata;

    // Model state
    tbl_pkg::tbl_entry_t    shadow [256];
    p4_proc_pkg::flow_key_t used_keys [NUM_ENTRIES];
    p4_proc_pkg::flow_key_t stream_key [2][STREAM_LEN];
    p4_proc_pkg::pkt_len_t  stream_len [2][STREAM_LEN];
    expect_t                exp_q0 [$];
    expect_t                exp_q1 [$];
    p4_proc_pkg::cnt_t      drop_model [2];
    logic [31:0]            rng_state;
    logic [31:0]            ready_bits;
    logic                   ready_random = 1'b0;
    int mismatch_count  = 0;
    int fail_count      = 0;
    int outputs_checked = 0;

    tb_clk_gen #(.CLK_PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(16),
                 .DRIVE_DELAY_NS(DRIVE_DELAY_NS)) i_clk_gen (.clk(axil_if), .rst_n(rst_n));

    p4_proc_top #(.KEY_WID(8)) i_dut (.*);

    // ==============================
    // Helpers
    // ==============================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Expected result from the shadow table, fields per the entry layout
    function automatic expect_t predict(input p4_proc_pkg::flow_key_t key,
                                        input p4_proc_pkg::pkt_len_t len);
        expect_t             e;
        tbl_pkg::tbl_entry_t ent;
        ent      = shadow[key];
        e.drop   = !ent[15] || ent[14];
        e.key    = key;
        e.len    = len;
        e.egress = ent[13];
        e.vlan   = ent[11:0];
        return e;
    endfunction

    // Class 0 invalid, 1 drop, 2 or 3 hit
    function automatic p4_proc_pkg::flow_key_t key_of_class(input int cls);
        return used_keys[(next_rand() % (NUM_ENTRIES / 4)) * 4 + cls];
    endfunction

    task automatic report_failure(input string what);
        fail_count++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got == expected) else begin
            mismatch_count++;
            $display("mismatch at %0t ns: %s expected 0x%0h got 0x%0h",
                     $time, name, expected, got);
        end
    endtask

    task automatic print_summary();
        $display("summary: %0d mismatches, %0d other errors, %0d outputs checked",
                 mismatch_count, fail_count, outputs_checked);
    endtask

    // ==============================
    // Management port
    // ==============================

    task automatic mgmt_access(input logic we, input logic [8:0] addr,
                               input tbl_pkg::tbl_entry_t wdata,
                               output tbl_pkg::tbl_entry_t rdata);
        int waited;
        mgmt_we    = we;
        mgmt_addr  = addr;
        mgmt_wdata = wdata;
        mgmt_req   = 1'b1;
        waited     = 0;
        while (!mgmt_ack && waited < MGMT_TIMEOUT) begin
            @(posedge axil_if);
            #(DRIVE_DELAY_NS);
            waited++;
        end
        assert (mgmt_ack) else report_failure($sformatf("no ack for access to 0x%03h", addr));
        rdata    = mgmt_rdata;
        mgmt_req = 1'b0;
        waited   = 0;
        while (mgmt_ack && waited < MGMT_TIMEOUT) begin
            @(posedge axil_if);
            #(DRIVE_DELAY_NS);
            waited++;
        end
        assert (!mgmt_ack) else report_failure("management ack stayed high after req fell");
    endtask

    task automatic read_check(input tbl_pkg::tbl_addr_t addr);
        tbl_pkg::tbl_entry_t rd;
        mgmt_access(1'b0, {1'b0, addr}, '0, rd);
        check_value($sformatf("mgmt_rdata @0x%02h", addr), rd, shadow[addr]);
    endtask

    task automatic check_drop_counters();
        tbl_pkg::tbl_entry_t rd;
        for (int p = 0; p < 2; p++) begin
            mgmt_access(1'b0, 9'h100 + 9'(p), '0, rd);
            check_value($sformatf("drop_cnt_%0d", p), rd, drop_model[p]);
        end
    endtask

    // ==============================
    // Descriptor streams
    // ==============================

    task automatic drive_port(input int port, input logic valid,
                              input p4_proc_pkg::flow_key_t key,
                              input p4_proc_pkg::pkt_len_t len);
        if (port == 0) begin
            in_valid_0 = valid;
            in_key_0   = key;
            in_len_0   = len;
        end else begin
            in_valid_1 = valid;
            in_key_1   = key;
            in_len_1   = len;
        end
    endtask

    task automatic send_desc(input int port, input p4_proc_pkg::flow_key_t key,
                             input p4_proc_pkg::pkt_len_t len);
        expect_t e;
        logic    accepted;
        int      waited;
        accepted = 1'b0;
        waited   = 0;
        drive_port(port, 1'b1, key, len);
        while (!accepted && waited < ACCEPT_TIMEOUT) begin
            @(negedge axil_if);
            accepted = (port == 0) ? in_ready_0 : in_ready_1;
            @(posedge axil_if);
            #(DRIVE_DELAY_NS);
            waited++;
        end
        drive_port(port, 1'b0, key, len);
        assert (accepted) else report_failure($sformatf("port %0d never took key 0x%02h",
                                                        port, key));
        if (accepted) begin
            e = predict(key, len);
            if (e.drop) begin
                drop_model[port]++;
            end else if (port == 0) begin
                exp_q0.push_back(e);
            end else begin
                exp_q1.push_back(e);
            end
        end
    endtask

    task automatic build_streams(input int n);
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < n; i++) begin
                stream_key[p][i] = used_keys[next_rand() % NUM_ENTRIES];
                stream_len[p][i] = p4_proc_pkg::pkt_len_t'(next_rand());
            end
        end
    endtask

    task automatic run_stream(input int port, input int n);
        for (int i = 0; i < n; i++) begin
            send_desc(port, stream_key[port][i], stream_len[port][i]);
        end
    endtask

    // Both engines idle, every expected output seen, last drop counted
    task automatic wait_idle();
        logic idle;
        int   waited;
        idle   = 1'b0;
        waited = 0;
        while (!idle && waited < DRAIN_TIMEOUT) begin
            @(negedge axil_if);
            idle = in_ready_0 && in_ready_1 && exp_q0.size() == 0 && exp_q1.size() == 0;
            waited++;
        end
        assert (idle) else report_failure($sformatf("not drained, %0d and %0d outputs missing",
                                                    exp_q0.size(), exp_q1.size()));
        repeat (2) @(posedge axil_if);
        #(DRIVE_DELAY_NS);
    endtask

    // ==============================
    // Compare process
    // ==============================

    task automatic check_output(input int port, input p4_proc_pkg::flow_key_t key,
                                input p4_proc_pkg::pkt_len_t len,
                                input p4_proc_pkg::port_t egress,
                                input p4_proc_pkg::vlan_t vlan);
        expect_t e;
        int      pending;
        pending = (port == 0) ? exp_q0.size() : exp_q1.size();
        assert (pending > 0) else report_failure($sformatf("port %0d output with nothing pending",
                                                           port));
        if (pending > 0) begin
            if (port == 0) begin
                e = exp_q0.pop_front();
            end else begin
                e = exp_q1.pop_front();
            end
            outputs_checked++;
            check_value($sformatf("out_key_%0d", port), key, e.key);
            check_value($sformatf("out_len_%0d", port), len, e.len);
            check_value($sformatf("out_egress_%0d", port), egress, e.egress);
            check_value($sformatf("out_vlan_%0d", port), vlan, e.vlan);
        end
    endtask

    // Mid-cycle sampling, a transfer completes at the next rising edge
    always @(negedge axil_if) begin
        if (!rst_n) begin
            check_value("in_ready_0", in_ready_0, 0);
            check_value("in_ready_1", in_ready_1, 0);
            check_value("out_valid_0", out_valid_0, 0);
            check_value("out_valid_1", out_valid_1, 0);
            check_value("mgmt_ack", mgmt_ack, 0);
        end else begin
            if (out_valid_0 && out_ready_0) begin
                check_output(0, out_key_0, out_len_0, out_egress_0, out_vlan_0);
            end
            if (out_valid_1 && out_ready_1) begin
                check_output(1, out_key_1, out_len_1, out_egress_1, out_vlan_1);
            end
        end
    end

    // Egress backpressure
    always begin
        @(posedge axil_if);
        #(DRIVE_DELAY_NS);
        if (!rst_n) begin
            out_ready_0 = 1'b0;
            out_ready_1 = 1'b0;
        end else if (ready_random) begin
            ready_bits  = next_rand();
            out_ready_0 = ready_bits[3];
            out_ready_1 = ready_bits[9];
        end else begin
            out_ready_0 = 1'b1;
            out_ready_1 = 1'b1;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        report_failure($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
        print_summary();
        $display("** FAIL **");
        $finish;
    end

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        tbl_pkg::tbl_entry_t    ent;
        tbl_pkg::tbl_entry_t    rd;
        p4_proc_pkg::flow_key_t addr;
        in_valid_0 = 1'b0;
        in_valid_1 = 1'b0;
        in_key_0   = '0;
        in_key_1   = '0;
        in_len_0   = '0;
        in_len_1   = '0;
        out_ready_0 = 1'b0;
        out_ready_1 = 1'b0;
        mgmt_req   = 1'b0;
        mgmt_we    = 1'b0;
        mgmt_addr  = '0;
        mgmt_wdata = '0;
        drop_model[0] = '0;
        drop_model[1] = '0;
        rng_state  = SEED;
        wait (rst_n === 1'b1);
        @(posedge axil_if);
        #(DRIVE_DELAY_NS);

        // Entries spread over the whole index range, then read back
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            addr = p4_proc_pkg::flow_key_t'(i * 8 + next_rand() % 8);
            ent  = tbl_pkg::tbl_entry_t'(next_rand());
            case (i % 4)
                0:       ent[15]    = 1'b0;
                1:       ent[15:14] = 2'b11;
                default: ent[15:14] = 2'b10;
            endcase
            used_keys[i] = addr;
            shadow[addr] = ent;
            mgmt_access(1'b1, {1'b0, addr}, ent, rd);
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            read_check(used_keys[i]);
        end
        check_drop_counters();

        // Hits on each port
        for (int p = 0; p < 2; p++) begin
            for (int n = 0; n < 4; n++) begin
                send_desc(p, key_of_class(2 + n % 2), p4_proc_pkg::pkt_len_t'(next_rand()));
            end
        end
        wait_idle();

        // Invalid and drop entries
        for (int p = 0; p < 2; p++) begin
            for (int n = 0; n < 4; n++) begin
                send_desc(p, key_of_class(n % 2), p4_proc_pkg::pkt_len_t'(next_rand()));
            end
        end
        wait_idle();
        check_drop_counters();

        // Both ports with table reads in between
        build_streams(STREAM_LEN);
        fork
            run_stream(0, STREAM_LEN);
            run_stream(1, STREAM_LEN);
            for (int i = 0; i < 8; i++) begin
                read_check(used_keys[next_rand() % NUM_ENTRIES]);
            end
        join
        wait_idle();
        check_drop_counters();

        // Random egress stalls
        build_streams(16);
        ready_random = 1'b1;
        fork
            run_stream(0, 16);
            run_stream(1, 16);
        join
        wait_idle();
        ready_random = 1'b0;
        check_drop_counters();

        print_summary();
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: project.f
common/p4_proc_pkg.sv
common/tbl_pkg.sv
common/tbl_bus_if.sv
table/tbl_mem.sv
table/tbl_arbiter.sv
match_action/flow_lookup.sv
hw/tbl_mgmt.sv
hw/p4_proc_top.sv
verif/tb_clk_gen.sv
verif/tb_p4_proc.sv
